// File: Makefile
TOP := pat_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: dv/pat_tb.sv
`timescale 1ns/1ps

module pat_tb;

	// ==============================
	// run length
	// ==============================
	localparam int RESET_CYCLES = 4;
	localparam int DRAIN        = 5;   // trailing nops to cover the commit and fieldwp lag
	localparam int N_REG_OPS    = 200;
	localparam int N_MEM_OPS    = 48;  // stam costs two slots
	localparam int N_FIELD_OPS  = 64;
	localparam int N_BRANCH_OPS = 64;
	localparam int N_OUT_ROUNDS = 24;  // ldi, out, setb per round
	localparam int PLANNED_CYCLES = RESET_CYCLES + N_REG_OPS + 3 * pat_pkg::DMEM_DEPTH
		+ 2 * N_MEM_OPS + N_FIELD_OPS + N_BRANCH_OPS + 3 * N_OUT_ROUNDS + 5 * DRAIN;
	localparam int TIMEOUT_CYCLES = 3 * PLANNED_CYCLES;

	// expected outputs right after one edge
	typedef struct packed {
		pat_pkg::pc_t     pc;
		pat_pkg::fieldp_t fieldp;
		pat_pkg::fieldp_t fieldwp;
		pat_pkg::data_t   acc;
		pat_pkg::data_t   out;
		pat_pkg::data_t   field_out;
		logic             field_we;
		pat_pkg::bufp_t   bufp;
	} obs_t;

	typedef struct packed {
		pat_pkg::data_t acc;
		pat_pkg::data_t out;
		pat_pkg::data_t field_out;
		logic           field_we;
		pat_pkg::bufp_t bufp;
	} core_t; // commit side of the model

	typedef struct packed {
		logic                en;
		pat_pkg::dmem_addr_t addr;
		pat_pkg::data_t      data;
	} store_t;

	typedef struct packed {
		core_t  core;
		store_t st;
	} result_t;

	logic             clk;
	logic             reset;
	pat_pkg::instr_t  i_instr;
	pat_pkg::data_t   i_field_in;
	pat_pkg::pc_t     o_pc;
	pat_pkg::fieldp_t o_fieldp;
	pat_pkg::fieldp_t o_fieldwp;
	pat_pkg::data_t   o_field_out;
	logic             o_field_write_en;
	pat_pkg::bufp_t   o_bufp;
	pat_pkg::data_t   o_acc;
	pat_pkg::data_t   o_out;

	obs_t             exp_obs [TIMEOUT_CYCLES];  // indexed by edge after reset
	pat_pkg::fieldp_t fp_hist [TIMEOUT_CYCLES];  // model fieldp after each edge
	pat_pkg::data_t   mem_model [pat_pkg::DMEM_DEPTH];
	core_t            core_model;
	store_t           st_old;      // reaches memory one slot later
	store_t           st_new;
	pat_pkg::pc_t     pc_model;
	pat_pkg::instr_t  prev1;       // slot now in the instruction register
	pat_pkg::instr_t  prev2;       // slot now in the control register
	int               slot_count;
	int               edge_idx;    // next edge the compare process looks at
	int               check_count;
	int               err_count;
	int               cycle_count;
	logic             check_on;

	tb_clock clock_gen
	(
		.o_clk (clk)
	);

	pat_top uut
	(
		.clk              (clk),
		.reset            (reset),
		.i_instr          (i_instr),
		.i_field_in       (i_field_in),
		.o_pc             (o_pc),
		.o_fieldp         (o_fieldp),
		.o_fieldwp        (o_fieldwp),
		.o_field_out      (o_field_out),
		.o_field_write_en (o_field_write_en),
		.o_bufp           (o_bufp),
		.o_acc            (o_acc),
		.o_out            (o_out)
	);

	// ==============================
	// reference model
	// ==============================
	function automatic pat_pkg::pc_t next_pc(pat_pkg::pc_t pc, pat_pkg::instr_t ins);
		pat_pkg::pc_t nx;
		nx = pc + 10'd1;
		if (ins.opcode == pat_pkg::I8_BF)
			nx = pc + {{2{ins.imm[7]}}, ins.imm}; // signed hop
		else if (ins.opcode == pat_pkg::I8_BB)
			nx = pc - {2'b00, ins.imm};           // always backwards
		return nx;
	endfunction

	function automatic result_t ref_model(pat_pkg::instr_t ins, core_t cur,
		pat_pkg::data_t mem [pat_pkg::DMEM_DEPTH], pat_pkg::data_t fbyte);
		result_t        r;
		pat_pkg::data_t a;
		pat_pkg::data_t m;
		pat_pkg::data_t y;
		logic           wr;  // op has a register result
		r.core          = cur;
		r.core.field_we = 1'b0;   // strobe lasts one cycle
		r.st            = '{en: 1'b0, addr: ins.imm[4:0], data: cur.acc};
		a               = ins.field_op ? fbyte : cur.acc;
		m               = mem[ins.imm[4:0]];
		y               = '0;
		wr              = 1'b1;
		if (ins.opcode != pat_pkg::OPC_PREFIX)
		begin
			case (ins.opcode)
				pat_pkg::I8_OR:   y = a | ins.imm;
				pat_pkg::I8_AND:  y = a & ins.imm;
				pat_pkg::I8_ADD:  y = a + ins.imm;
				pat_pkg::I8_SUB:  y = a - ins.imm;
				pat_pkg::I8_LDI:  y = ins.imm;
				pat_pkg::I8_LDM:  y = m;
				pat_pkg::I8_ADDM: y = a + m;
				pat_pkg::I8_SUBM: y = a - m;
				pat_pkg::I8_ORM:  y = a | m;
				pat_pkg::I8_ANDM: y = a & m;
				pat_pkg::I8_STAM:
				begin
					wr      = 1'b0;
					r.st.en = 1'b1;
				end
				default:          wr = 1'b0; // bf, bb and the holes
			endcase
		end
		else if (ins.imm[7:4] != pat_pkg::OPC_PREFIX)
		begin
			case (ins.imm[7:4])
				pat_pkg::I3_SHL: y = a << ins.imm[2:0];
				pat_pkg::I3_SHR: y = a >> ins.imm[2:0];
				pat_pkg::I3_ASR: y = pat_pkg::data_t'($signed(a) >>> ins.imm[2:0]);
				pat_pkg::I3_OUT:
				begin
					wr         = 1'b0;
					r.core.out = cur.acc;
				end
				pat_pkg::I3_SETB:
				begin
					wr          = 1'b0;
					r.core.bufp = ins.imm[2:0];
				end
				default:         wr = 1'b0;
			endcase
		end
		else
		begin
			y  = ~a;
			wr = (ins.imm[3:0] == pat_pkg::I0_NOT); // everything else in i0 is a nop
		end
		if (wr && ins.field_op)
		begin
			r.core.field_out = y;
			r.core.field_we  = 1'b1;
		end
		else if (wr)
			r.core.acc = y;
		return r;
	endfunction

	// ==============================
	// stimulus helpers
	// ==============================
	function automatic pat_pkg::instr_t make_instr(logic [3:0] opcode, pat_pkg::data_t imm,
		logic field_op);
		pat_pkg::instr_t ins;
		ins.fieldp   = pat_pkg::fieldp_t'($urandom);
		ins.cond     = 2'($urandom);  // ignored by the core
		ins.field_op = field_op;
		ins.opcode   = opcode;
		ins.imm      = imm;
		return ins;
	endfunction

	function automatic pat_pkg::instr_t rand_reg_op(logic field_op);
		pat_pkg::data_t  rnd;
		pat_pkg::instr_t ins;
		int              kind;
		rnd  = pat_pkg::data_t'($urandom);
		kind = int'($urandom_range(8, 0));
		case (kind)
			0: ins = make_instr(pat_pkg::I8_LDI, rnd, field_op);
			1: ins = make_instr(pat_pkg::I8_OR, rnd, field_op);
			2: ins = make_instr(pat_pkg::I8_AND, rnd, field_op);
			3: ins = make_instr(pat_pkg::I8_ADD, rnd, field_op);
			4: ins = make_instr(pat_pkg::I8_SUB, rnd, field_op);
			5: ins = make_instr(pat_pkg::OPC_PREFIX, {pat_pkg::OPC_PREFIX, pat_pkg::I0_NOT},
				field_op);
			6: ins = make_instr(pat_pkg::OPC_PREFIX, {pat_pkg::I3_SHL, rnd[3:0]}, field_op);
			7: ins = make_instr(pat_pkg::OPC_PREFIX, {pat_pkg::I3_SHR, rnd[3:0]}, field_op);
			default: ins = make_instr(pat_pkg::OPC_PREFIX, {pat_pkg::I3_ASR, rnd[3:0]},
				field_op);
		endcase
		return ins;
	endfunction

	// i0 nop or one of the unused i8 codes
	function automatic pat_pkg::instr_t rand_nop();
		pat_pkg::instr_t ins;
		int              kind;
		kind = int'($urandom_range(2, 0));
		case (kind)
			0: ins = make_instr(4'd10, pat_pkg::data_t'($urandom), 1'b0);
			1: ins = make_instr(4'd12, pat_pkg::data_t'($urandom), 1'b0);
			default: ins = make_instr(pat_pkg::OPC_PREFIX,
				{pat_pkg::OPC_PREFIX, pat_pkg::I0_NOP}, 1'b0);
		endcase
		return ins;
	endfunction

	// called on a falling edge to drive slot n and record what edge n should show
	task automatic drive_slot(input pat_pkg::instr_t ins);
		pat_pkg::data_t   fbyte;
		pat_pkg::fieldp_t fwp;
		result_t          r;
		int               n;
		n          = slot_count;
		fbyte      = pat_pkg::data_t'($urandom);
		i_instr    = ins;
		i_field_in = fbyte;   // seen by the slot that commits at edge n
		pc_model   = next_pc(pc_model, prev1);
		fp_hist[n] = prev1.fieldp;
		fwp        = (n >= pat_pkg::FIELD_LATENCY) ? fp_hist[n - pat_pkg::FIELD_LATENCY] : '0;
		if (st_old.en)
			mem_model[st_old.addr] = st_old.data; // stores two slots back are visible
		r          = ref_model(prev2, core_model, mem_model, fbyte);
		core_model = r.core;
		st_old     = st_new;
		st_new     = r.st;
		exp_obs[n] = '{pc: pc_model, fieldp: fp_hist[n], fieldwp: fwp, acc: core_model.acc,
			out: core_model.out, field_out: core_model.field_out,
			field_we: core_model.field_we, bufp: core_model.bufp};
		prev2      = prev1;
		prev1      = ins;
		slot_count = n + 1;
		@(negedge clk);
	endtask

	task automatic end_test(input string name, input int errs_before);
		repeat (DRAIN)
			drive_slot(pat_pkg::NOP_INSTR);
		wait (edge_idx == slot_count);  // compare has caught up
		$display("%s: %0d errors", name, err_count - errs_before);
	endtask

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("error %0d ns: %s is 0x%0h, expected 0x%0h (edge %0d)",
			$time, name, got, exp, edge_idx);
		err_count++;
	endtask

	// ==============================
	// compare
	// ==============================
	initial
	begin
		obs_t got;
		obs_t exp;
		wait (check_on);
		forever
		begin
			@(negedge clk);  // outputs settled since the rising edge
			if (edge_idx < slot_count)
			begin
				got = '{pc: o_pc, fieldp: o_fieldp, fieldwp: o_fieldwp, acc: o_acc,
					out: o_out, field_out: o_field_out, field_we: o_field_write_en,
					bufp: o_bufp};
				exp = exp_obs[edge_idx];
				check_count += 8;
				if (got.pc !== exp.pc)
					report_mismatch("o_pc", int'(got.pc), int'(exp.pc));
				if (got.fieldp !== exp.fieldp)
					report_mismatch("o_fieldp", int'(got.fieldp), int'(exp.fieldp));
				if (got.fieldwp !== exp.fieldwp)
					report_mismatch("o_fieldwp", int'(got.fieldwp), int'(exp.fieldwp));
				if (got.acc !== exp.acc)
					report_mismatch("o_acc", int'(got.acc), int'(exp.acc));
				if (got.out !== exp.out)
					report_mismatch("o_out", int'(got.out), int'(exp.out));
				if (got.field_out !== exp.field_out)
					report_mismatch("o_field_out", int'(got.field_out), int'(exp.field_out));
				if (got.field_we !== exp.field_we)
					report_mismatch("o_field_write_en", int'(got.field_we), int'(exp.field_we));
				if (got.bufp !== exp.bufp)
					report_mismatch("o_bufp", int'(got.bufp), int'(exp.bufp));
				edge_idx++;
			end
		end
	end

	// ==============================
	// timeout
	// ==============================
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ==============================
	// tests
	// ==============================
	initial
	begin
		int         errs;
		int         kind;
		logic [3:0] opc;
		void'($urandom(32'h53408135));
		reset       = 1'b1;
		i_instr     = pat_pkg::NOP_INSTR;
		i_field_in  = '0;
		check_on    = 1'b0;
		slot_count  = 0;
		edge_idx    = 0;
		check_count = 0;
		err_count   = 0;
		pc_model    = '0;
		prev1       = pat_pkg::NOP_INSTR;  // matches the reset instruction register
		prev2       = pat_pkg::NOP_INSTR;
		core_model  = '0;
		st_old      = '0;
		st_new      = '0;
		for (int a = 0; a < pat_pkg::DMEM_DEPTH; a++)
			mem_model[a] = '0;

		// test 1 checks the reset values
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		errs  = err_count;
		check_count += 7;
		if (o_pc !== '0)
			report_mismatch("o_pc after reset", int'(o_pc), 0);
		if (o_acc !== '0)
			report_mismatch("o_acc after reset", int'(o_acc), 0);
		if (o_out !== '0)
			report_mismatch("o_out after reset", int'(o_out), 0);
		if (o_bufp !== '0)
			report_mismatch("o_bufp after reset", int'(o_bufp), 0);
		if (o_fieldp !== '0)
			report_mismatch("o_fieldp after reset", int'(o_fieldp), 0);
		if (o_fieldwp !== '0)
			report_mismatch("o_fieldwp after reset", int'(o_fieldwp), 0);
		if (o_field_write_en !== 1'b0)
			report_mismatch("o_field_write_en after reset", int'(o_field_write_en), 0);
		$display("test 1 reset values: %0d errors", err_count - errs);
		check_on = 1'b1;

		// test 2 runs accumulator ops
		errs = err_count;
		repeat (N_REG_OPS)
			drive_slot(rand_reg_op(1'b0));
		end_test("test 2 register and shift ops", errs);

		// test 3 fills memory and then mixes memory ops
		errs = err_count;
		for (int a = 0; a < pat_pkg::DMEM_DEPTH; a++)
		begin
			drive_slot(make_instr(pat_pkg::I8_LDI, pat_pkg::data_t'($urandom), 1'b0));
			drive_slot(make_instr(pat_pkg::I8_STAM, {3'($urandom), 5'(a)}, 1'b0));
			drive_slot(rand_nop());  // load after store needs one gap
		end
		repeat (N_MEM_OPS)
		begin
			kind = int'($urandom_range(5, 0));
			case (kind)
				0: opc = pat_pkg::I8_LDM;
				1: opc = pat_pkg::I8_ADDM;
				2: opc = pat_pkg::I8_SUBM;
				3: opc = pat_pkg::I8_ORM;
				4: opc = pat_pkg::I8_ANDM;
				default: opc = pat_pkg::I8_STAM;
			endcase
			drive_slot(make_instr(opc, pat_pkg::data_t'($urandom), 1'b0));
			if (opc == pat_pkg::I8_STAM)
				drive_slot(rand_nop());
		end
		end_test("test 3 memory ops", errs);

		// test 4 mixes field ops back to back and with gaps
		errs = err_count;
		repeat (N_FIELD_OPS)
		begin
			if ($urandom_range(3, 0) != 0)
				drive_slot(rand_reg_op(1'b1));
			else
				drive_slot(rand_nop());
		end
		end_test("test 4 field ops", errs);

		// test 5 runs branches
		errs = err_count;
		repeat (N_BRANCH_OPS)
		begin
			kind = int'($urandom_range(2, 0));
			if (kind == 0)
				drive_slot(make_instr(pat_pkg::I8_BF, pat_pkg::data_t'($urandom), 1'b0));
			else if (kind == 1)
				drive_slot(make_instr(pat_pkg::I8_BB, pat_pkg::data_t'($urandom), 1'b0));
			else
				drive_slot(rand_nop());
		end
		end_test("test 5 branches", errs);

		// test 6 covers out and setb
		errs = err_count;
		repeat (N_OUT_ROUNDS)
		begin
			drive_slot(make_instr(pat_pkg::I8_LDI, pat_pkg::data_t'($urandom), 1'b0));
			drive_slot(make_instr(pat_pkg::OPC_PREFIX, {pat_pkg::I3_OUT, 4'($urandom)}, 1'b0));
			drive_slot(make_instr(pat_pkg::OPC_PREFIX, {pat_pkg::I3_SETB, 4'($urandom)}, 1'b0));
		end
		end_test("test 6 out and setb", errs);

		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
	output logic o_clk
);

	localparam int HALF_PERIOD = 20; // 40 ns period

	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = ~o_clk; // first rising edge at 20 ns
	end

endmodule

// File: filelist.f
verilog/pat_pkg.sv
verilog/pat_alu.sv
verilog/pat_decoder.sv
verilog/pat_data_mem.sv
verilog/pat_program_counter.sv
verilog/pat_field_pointer.sv
verilog/pat_commit.sv
verilog/pat_top.sv
dv/tb_clock.sv
dv/pat_tb.sv

// File: verilog/pat_alu.sv
`timescale 1ns/1ps

module pat_alu
(
	input  pat_pkg::data_t   i_a,
	input  pat_pkg::data_t   i_b,
	input  pat_pkg::alu_op_e i_op,
	output pat_pkg::data_t   o_y
);

	logic           sub;
	pat_pkg::data_t addsub_b;
	pat_pkg::data_t sum;
	logic [2:0]     shamt;

	assign sub   = (i_op == pat_pkg::ALU_SUB);
	assign shamt = i_b[2:0];

	// one adder for both, sub is a + ~b + 1
	assign addsub_b = sub ? ~i_b : i_b;
	assign sum      = i_a + addsub_b + {{($bits(pat_pkg::data_t) - 1){1'b0}}, sub};

	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_OR:  o_y = i_a | i_b;
			pat_pkg::ALU_AND: o_y = i_a & i_b;
			pat_pkg::ALU_ADD,
			pat_pkg::ALU_SUB: o_y = sum;
			pat_pkg::ALU_NOT: o_y = ~i_a;
			pat_pkg::ALU_SHL: o_y = i_a << shamt;  // zero fill
			pat_pkg::ALU_SHR: o_y = i_a >> shamt;
			pat_pkg::ALU_ASR: o_y = $unsigned($signed(i_a) >>> shamt); // keeps sign
			default:          o_y = i_b;           // pass, for ldi/ldm
		endcase
	end

endmodule

// File: verilog/pat_commit.sv
`timescale 1ns/1ps

module pat_commit
(
	input  logic                clk,
	input  logic                reset,
	input  pat_pkg::decoded_t   i_dec,
	input  pat_pkg::data_t      i_field_in,      // byte at fieldp for the commit cycle
	output pat_pkg::data_t      o_acc,
	output pat_pkg::data_t      o_out,
	output pat_pkg::data_t      o_field_out,
	output logic                o_field_write_en,
	output pat_pkg::bufp_t      o_bufp,
	output logic                o_wr_en,
	output pat_pkg::dmem_addr_t o_wr_addr,
	output pat_pkg::data_t      o_wr_data
);

	pat_pkg::data_t acc_q;
	pat_pkg::data_t out_q;
	pat_pkg::data_t field_out_q;
	logic           field_we_q;
	pat_pkg::bufp_t bufp_q;
	pat_pkg::data_t acc_y;
	pat_pkg::data_t field_y;

	// two alus so neither needs an operand mux
	pat_alu acc_alu
	(
		.i_a  (acc_q),
		.i_b  (i_dec.operand_b),
		.i_op (i_dec.alu_op),
		.o_y  (acc_y)
	);

	pat_alu field_alu
	(
		.i_a  (i_field_in),
		.i_b  (i_dec.operand_b),
		.i_op (i_dec.alu_op),
		.o_y  (field_y)
	);

	// ==============================
	// commit edge
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc_q       <= '0;
			out_q       <= '0;
			field_out_q <= '0;
			field_we_q  <= 1'b0;
			bufp_q      <= '0;
		end
		else
		begin
			if (i_dec.dest_acc)
				acc_q <= acc_y;
			if (i_dec.dest_field)
				field_out_q <= field_y;
			field_we_q <= i_dec.dest_field;   // one cycle per field op
			if (i_dec.do_out)
				out_q <= acc_q;
			if (i_dec.do_setb)
				bufp_q <= i_dec.operand_b[2:0];
		end
	end

	// store goes out now so memory writes on this same edge
	assign o_wr_en   = i_dec.dest_dmem;
	assign o_wr_addr = i_dec.wr_addr;
	assign o_wr_data = acc_q;

	assign o_acc            = acc_q;
	assign o_out            = out_q;
	assign o_field_out      = field_out_q;
	assign o_field_write_en = field_we_q;
	assign o_bufp           = bufp_q;

	// the field buffer never gets a strobe with an unknown byte
	assert property (@(posedge clk) disable iff (reset)
		o_field_write_en |-> !$isunknown(o_field_out));

endmodule

// File: verilog/pat_data_mem.sv
`timescale 1ns/1ps

module pat_data_mem
(
	input  logic                clk,
	input  pat_pkg::dmem_addr_t i_rd_addr,
	input  logic                i_wr_en,
	input  pat_pkg::dmem_addr_t i_wr_addr,
	input  pat_pkg::data_t      i_wr_data,
	output pat_pkg::data_t      o_rd_data
);

	pat_pkg::data_t mem [pat_pkg::DMEM_DEPTH];

	// read is combinational, decode samples it the same cycle
	assign o_rd_data = mem[i_rd_addr];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data; // store lands on the commit edge
	end

	// stage 2 must present a clean address with every store
	assert property (@(posedge clk) i_wr_en |-> !$isunknown(i_wr_addr));

endmodule

// File: verilog/pat_decoder.sv
`timescale 1ns/1ps

module pat_decoder
(
	input  logic                clk,
	input  logic                reset,
	input  pat_pkg::instr_t     i_instr,
	input  pat_pkg::data_t      i_rd_data,     // async answer to o_rd_addr
	output pat_pkg::dmem_addr_t o_rd_addr,
	output pat_pkg::decoded_t   o_dec,
	output pat_pkg::branch_e    o_branch,
	output pat_pkg::data_t      o_offset,
	output pat_pkg::fieldp_t    o_fieldp_next
);

	pat_pkg::instr_t   instr_q;     // instruction register
	pat_pkg::decoded_t dec_d;
	pat_pkg::decoded_t dec_q;       // stage-1 control register
	logic              is_i8;
	logic              is_i3;
	logic              commit_reg;  // op writes acc or field
	logic [3:0]        opc_i3;
	logic [3:0]        opc_i0;

	assign opc_i3 = instr_q.imm[7:4];
	assign opc_i0 = instr_q.imm[3:0];

	// classify by prefix and treat anything left over as i0
	assign is_i8 = (instr_q.opcode != pat_pkg::OPC_PREFIX);
	assign is_i3 = !is_i8 && (opc_i3 != pat_pkg::OPC_PREFIX);

	// ==============================
	// decode
	// ==============================
	always_comb
	begin
		dec_d           = pat_pkg::DEC_NOP;
		dec_d.operand_b = instr_q.imm;       // plain i8 immediate
		dec_d.wr_addr   = instr_q.imm[4:0];  // only used by stam
		commit_reg      = 1'b0;
		if (is_i8)
		begin
			commit_reg = instr_q.opcode inside {pat_pkg::I8_OR, pat_pkg::I8_AND,
				pat_pkg::I8_ADDM, pat_pkg::I8_SUBM, pat_pkg::I8_ADD, pat_pkg::I8_SUB,
				pat_pkg::I8_LDI, pat_pkg::I8_LDM, pat_pkg::I8_ORM, pat_pkg::I8_ANDM};
			if (instr_q.opcode inside {pat_pkg::I8_ADDM, pat_pkg::I8_SUBM,
				pat_pkg::I8_LDM, pat_pkg::I8_ORM, pat_pkg::I8_ANDM})
				dec_d.operand_b = i_rd_data;  // memory operand at imm[4:0]
			case (instr_q.opcode)
				pat_pkg::I8_OR, pat_pkg::I8_ORM:   dec_d.alu_op = pat_pkg::ALU_OR;
				pat_pkg::I8_AND, pat_pkg::I8_ANDM: dec_d.alu_op = pat_pkg::ALU_AND;
				pat_pkg::I8_ADD, pat_pkg::I8_ADDM: dec_d.alu_op = pat_pkg::ALU_ADD;
				pat_pkg::I8_SUB, pat_pkg::I8_SUBM: dec_d.alu_op = pat_pkg::ALU_SUB;
				default:                           dec_d.alu_op = pat_pkg::ALU_PASS; // ldi, ldm
			endcase
			dec_d.dest_dmem = (instr_q.opcode == pat_pkg::I8_STAM);
		end
		else if (is_i3)
		begin
			dec_d.operand_b = {5'b0, instr_q.imm[2:0]}; // shift amount or bufp
			commit_reg      = opc_i3 inside {pat_pkg::I3_SHL, pat_pkg::I3_SHR, pat_pkg::I3_ASR};
			case (opc_i3)
				pat_pkg::I3_SHL: dec_d.alu_op = pat_pkg::ALU_SHL;
				pat_pkg::I3_SHR: dec_d.alu_op = pat_pkg::ALU_SHR;
				pat_pkg::I3_ASR: dec_d.alu_op = pat_pkg::ALU_ASR;
				default:         dec_d.alu_op = pat_pkg::ALU_PASS;
			endcase
			dec_d.do_out  = (opc_i3 == pat_pkg::I3_OUT);
			dec_d.do_setb = (opc_i3 == pat_pkg::I3_SETB);
		end
		else
		begin
			// in i0 space only not commits
			commit_reg   = (opc_i0 == pat_pkg::I0_NOT);
			dec_d.alu_op = pat_pkg::ALU_NOT;
		end
		dec_d.dest_acc   = commit_reg && !instr_q.field_op;
		dec_d.dest_field = commit_reg && instr_q.field_op;
	end

	// branches act straight out of the instruction register
	assign o_branch = !is_i8 ? pat_pkg::BR_NONE :
		(instr_q.opcode == pat_pkg::I8_BF) ? pat_pkg::BR_FWD :
		(instr_q.opcode == pat_pkg::I8_BB) ? pat_pkg::BR_BACK : pat_pkg::BR_NONE;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q <= pat_pkg::NOP_INSTR; // start on a nop
			dec_q   <= pat_pkg::DEC_NOP;
		end
		else
		begin
			instr_q <= i_instr;
			dec_q   <= dec_d;
		end
	end

	assign o_rd_addr     = instr_q.imm[4:0];
	assign o_offset      = instr_q.imm;      // branch distance
	assign o_fieldp_next = instr_q.fieldp;
	assign o_dec         = dec_q;

	// a committing op never carries an unwritten memory byte or a bad immediate
	assert property (@(posedge clk) disable iff (reset)
		(o_dec.dest_acc || o_dec.dest_field) |-> !$isunknown(o_dec.operand_b));

endmodule

// File: verilog/pat_field_pointer.sv
`timescale 1ns/1ps

module pat_field_pointer
(
	input  logic             clk,
	input  logic             reset,
	input  pat_pkg::fieldp_t i_fieldp_next,
	output pat_pkg::fieldp_t o_fieldp,   // read side
	output pat_pkg::fieldp_t o_fieldwp   // write side, trails by FIELD_LATENCY
);

	pat_pkg::fieldp_t fieldp_q;
	pat_pkg::fieldp_t [pat_pkg::FIELD_LATENCY-1:0] hist; // [0] is newest

	// ==============================
	// read pointer and history
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fieldp_q <= '0;
			hist     <= '0;
		end
		else
		begin
			fieldp_q <= i_fieldp_next;
			hist     <= {hist[pat_pkg::FIELD_LATENCY-2:0], fieldp_q};
		end
	end

	assign o_fieldp  = fieldp_q;
	assign o_fieldwp = hist[pat_pkg::FIELD_LATENCY-1]; // matches the buffer's rmw delay

endmodule

// File: verilog/pat_pkg.sv
package pat_pkg;

	// ==============================
	// widths
	// ==============================
	typedef logic [7:0] data_t;       // acc, field and memory byte
	typedef logic [9:0] pc_t;         // instruction address, wraps at 1024
	typedef logic [4:0] fieldp_t;     // field buffer pointer
	typedef logic [2:0] bufp_t;       // buffer select
	typedef logic [4:0] dmem_addr_t;  // data memory address

	localparam logic [3:0] OPC_PREFIX = 4'b1111; // escapes i8 -> i3 and i3 -> i0
	localparam int FIELD_LATENCY = 4;            // field read to write, in cycles
	localparam int DMEM_DEPTH = 32;

	// 20-bit instruction word, msb first
	typedef struct packed {
		fieldp_t    fieldp;   // field pointer for this slot
		logic [1:0] cond;     // carried along, never decoded
		logic       field_op; // result goes to field instead of acc
		logic [3:0] opcode;   // i8 opcode or prefix
		data_t      imm;      // i3/i0 opcodes live in here too
	} instr_t;

	// ==============================
	// opcode spaces
	// ==============================
	typedef enum logic [3:0] {
		I8_OR   = 4'd0,
		I8_AND  = 4'd1,
		I8_ADDM = 4'd2,
		I8_SUBM = 4'd3,
		I8_ADD  = 4'd4,
		I8_SUB  = 4'd5,
		I8_LDI  = 4'd6,
		I8_LDM  = 4'd7,
		I8_BF   = 4'd8,
		I8_BB   = 4'd9,
		I8_STAM = 4'd11,
		I8_ORM  = 4'd13,
		I8_ANDM = 4'd14
	} op_i8_e; // 10 and 12 are holes, they fall through as nop

	typedef enum logic [3:0] {
		I3_SHL  = 4'd0,
		I3_SHR  = 4'd2,
		I3_ASR  = 4'd3,
		I3_OUT  = 4'd8,
		I3_SETB = 4'd9
	} op_i3_e;

	typedef enum logic [3:0] {
		I0_NOT = 4'd0,
		I0_NOP = 4'd5
	} op_i0_e;

	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_ADD, ALU_SUB, ALU_NOT,
		ALU_SHL, ALU_SHR, ALU_ASR, ALU_PASS
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE, BR_FWD, BR_BACK
	} branch_e;

	// stage-1 result handed to commit
	typedef struct packed {
		alu_op_e    alu_op;
		data_t      operand_b;  // imm, memory byte or 3-bit amount
		logic       dest_acc;
		logic       dest_field;
		logic       dest_dmem;  // stam
		logic       do_out;
		logic       do_setb;
		dmem_addr_t wr_addr;
	} decoded_t;

	localparam instr_t NOP_INSTR = '{fieldp: '0, cond: '0, field_op: 1'b0,
		opcode: OPC_PREFIX, imm: {OPC_PREFIX, I0_NOP}};

	localparam decoded_t DEC_NOP = '{alu_op: ALU_PASS, operand_b: '0, dest_acc: 1'b0,
		dest_field: 1'b0, dest_dmem: 1'b0, do_out: 1'b0, do_setb: 1'b0, wr_addr: '0};

endpackage

// File: verilog/pat_program_counter.sv
`timescale 1ns/1ps

module pat_program_counter
(
	input  logic             clk,
	input  logic             reset,
	input  pat_pkg::branch_e i_branch,
	input  pat_pkg::data_t   i_offset,
	output pat_pkg::pc_t     o_pc
);

	pat_pkg::pc_t pc_q;
	pat_pkg::pc_t off_sext;  // bf distance, signed
	pat_pkg::pc_t off_zext;  // bb distance, always backwards

	assign off_sext = {{($bits(pat_pkg::pc_t) - $bits(pat_pkg::data_t)){i_offset[7]}}, i_offset};
	assign off_zext = {{($bits(pat_pkg::pc_t) - $bits(pat_pkg::data_t)){1'b0}}, i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			pc_q <= '0;
		else
			case (i_branch)
				pat_pkg::BR_FWD:  pc_q <= pc_q + off_sext;
				pat_pkg::BR_BACK: pc_q <= pc_q - off_zext;
				default:          pc_q <= pc_q + 1'b1; // wraps mod 1024
			endcase
	end

	assign o_pc = pc_q;

endmodule

// File: verilog/pat_top.sv
`timescale 1ns/1ps

module pat_top
(
	input  logic             clk,
	input  logic             reset,
	input  pat_pkg::instr_t  i_instr,
	input  pat_pkg::data_t   i_field_in,
	output pat_pkg::pc_t     o_pc,
	output pat_pkg::fieldp_t o_fieldp,
	output pat_pkg::fieldp_t o_fieldwp,
	output pat_pkg::data_t   o_field_out,
	output logic             o_field_write_en,
	output pat_pkg::bufp_t   o_bufp,
	output pat_pkg::data_t   o_acc,
	output pat_pkg::data_t   o_out
);

	pat_pkg::dmem_addr_t rd_addr;
	pat_pkg::data_t      rd_data;
	pat_pkg::decoded_t   dec;
	pat_pkg::branch_e    branch;
	pat_pkg::data_t      offset;
	pat_pkg::fieldp_t    fieldp_next;
	logic                wr_en;
	pat_pkg::dmem_addr_t wr_addr;
	pat_pkg::data_t      wr_data;

	// ==============================
	// stage 1
	// ==============================
	pat_decoder u_decoder
	(
		.clk           (clk),
		.reset         (reset),
		.i_instr       (i_instr),
		.i_rd_data     (rd_data),
		.o_rd_addr     (rd_addr),
		.o_dec         (dec),
		.o_branch      (branch),
		.o_offset      (offset),
		.o_fieldp_next (fieldp_next)
	);

	pat_data_mem u_data_mem
	(
		.clk       (clk),
		.i_rd_addr (rd_addr),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.o_rd_data (rd_data)
	);

	pat_program_counter u_program_counter
	(
		.clk      (clk),
		.reset    (reset),
		.i_branch (branch),
		.i_offset (offset),
		.o_pc     (o_pc)
	);

	pat_field_pointer u_field_pointer
	(
		.clk           (clk),
		.reset         (reset),
		.i_fieldp_next (fieldp_next),
		.o_fieldp      (o_fieldp),
		.o_fieldwp     (o_fieldwp)
	);

	// ==============================
	// stage 2
	// ==============================
	pat_commit u_commit
	(
		.clk              (clk),
		.reset            (reset),
		.i_dec            (dec),
		.i_field_in       (i_field_in),
		.o_acc            (o_acc),
		.o_out            (o_out),
		.o_field_out      (o_field_out),
		.o_field_write_en (o_field_write_en),
		.o_bufp           (o_bufp),
		.o_wr_en          (wr_en),
		.o_wr_addr        (wr_addr),
		.o_wr_data        (wr_data)
	);

endmodule
